/* files.f */
ps2_pkg.sv
zxkb_pkg.sv
scan_event_if.sv
ps2_port.sv
ps2_host_to_kb.sv
scancode_to_speccy.sv
ps2_keyb.sv
tb_ps2_keyb.sv

/* ps2_host_to_kb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_host_to_kb import ps2_pkg::*; #(
    parameter int FILTER_LEN     = 8,
    parameter int INHIBIT_CYCLES = 12000,
    parameter int TIMEOUT_CYCLES = 2000000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      ps2_clk_in,
    input  logic      ps2_data_in,
    output logic      ps2_clk_pull,
    output logic      ps2_data_pull,
    input  ps2_byte_t data,
    input  logic      dataload,
    output logic      busy,
    output logic      error
);

    localparam int INH_W = $clog2(INHIBIT_CYCLES + 1);
    localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [1:0]            clk_sync;
    logic [1:0]            data_sync;
    logic [FILTER_LEN-1:0] clk_hist;
    logic                  clk_filt;
    logic                  clk_filt_d;
    logic                  fall_edge;

    tx_state_t             state;
    ps2_byte_t             shreg;
    logic                  parity_bit;
    logic [2:0]            bit_cnt;
    logic [INH_W-1:0]      inhibit_cnt;
    logic [TMO_W-1:0]      timeout_cnt;
    logic                  timed_out;
    logic                  ack_missing;

    // Clock is accepted once the whole sample window agrees
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync   <= 2'b11;
            data_sync  <= 2'b11;
            clk_hist   <= '1;
            clk_filt   <= 1'b1;
            clk_filt_d <= 1'b1;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk_in};
            data_sync  <= {data_sync[0], ps2_data_in};
            clk_hist   <= {clk_hist[FILTER_LEN-2:0], clk_sync[1]};
            clk_filt_d <= clk_filt;
            if (&clk_hist) begin
                clk_filt <= 1'b1;
            end else if (~|clk_hist) begin
                clk_filt <= 1'b0;
            end
        end
    end

    assign fall_edge = clk_filt_d & ~clk_filt;
    assign timed_out = (timeout_cnt == TMO_W'(TIMEOUT_CYCLES - 1));

    // Byte and odd parity captured at load
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && dataload) begin
            shreg      <= data;
            parity_bit <= ~^data;
        end
    end

    // ----------------------------------------
    // Transmit FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= TX_IDLE;
            busy          <= 1'b0;
            error         <= 1'b0;
            ps2_clk_pull  <= 1'b0;
            ps2_data_pull <= 1'b0;
            bit_cnt       <= '0;
            inhibit_cnt   <= '0;
            timeout_cnt   <= '0;
            ack_missing   <= 1'b0;
        end else begin
            if (state == TX_IDLE) begin
                timeout_cnt <= '0;
            end else begin
                timeout_cnt <= timeout_cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    if (dataload) begin
                        busy         <= 1'b1;
                        ps2_clk_pull <= 1'b1;
                        inhibit_cnt  <= '0;
                        ack_missing  <= 1'b1;
                        state        <= TX_INHIBIT;
                    end
                end
                TX_INHIBIT: begin
                    if (inhibit_cnt == INH_W'(INHIBIT_CYCLES - 1)) begin
                        ps2_data_pull <= 1'b1;
                        state         <= TX_START;
                    end else begin
                        inhibit_cnt <= inhibit_cnt + 1'b1;
                    end
                end
                TX_START: begin
                    // Device takes over the clock from here
                    ps2_clk_pull <= 1'b0;
                    if (fall_edge) begin
                        ps2_data_pull <= ~shreg[0];
                        bit_cnt       <= 3'd1;
                        state         <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (fall_edge) begin
                        if (bit_cnt == 3'd0) begin
                            ps2_data_pull <= ~parity_bit;
                            state         <= TX_PARITY;
                        end else begin
                            ps2_data_pull <= ~shreg[bit_cnt];
                            bit_cnt       <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (fall_edge) begin
                        ps2_data_pull <= 1'b0;
                        state         <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    // Ack is the device holding data low
                    if (fall_edge) begin
                        ack_missing <= data_sync[1];
                        state       <= TX_ACK;
                    end
                end
                TX_ACK: begin
                    if (clk_filt) begin
                        state <= TX_DONE;
                    end
                end
                TX_DONE: begin
                    busy          <= 1'b0;
                    error         <= ack_missing;
                    ps2_clk_pull  <= 1'b0;
                    ps2_data_pull <= 1'b0;
                    state         <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase

            // Watchdog abort
            if (timed_out && state != TX_IDLE && state != TX_DONE) begin
                ack_missing   <= 1'b1;
                ps2_clk_pull  <= 1'b0;
                ps2_data_pull <= 1'b0;
                state         <= TX_DONE;
            end
        end
    end

endmodule

`default_nettype wire

/* ps2_keyb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyb import zxkb_pkg::*; #(
    parameter int FILTER_LEN     = 8,
    parameter int INHIBIT_CYCLES = 12000,
    parameter int TIMEOUT_CYCLES = 2000000
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         ps2_clk_in,
    input  logic         ps2_data_in,
    output logic         ps2_clk_pull,
    output logic         ps2_data_pull,
    input  zx_row_t      rows,
    output zx_col_t      cols,
    input  zx_reg_addr_t zxuno_addr,
    input  logic         zxuno_regrd,
    input  logic         zxuno_regwr,
    input  logic         regaddr_changed,
    input  logic [7:0]   din,
    output logic [7:0]   keymap_dout,
    output logic [7:0]   scancode_dout,
    output logic [7:0]   kbstatus_dout,
    output logic         oe_n_keymap,
    output logic         oe_n_scancode,
    output logic         oe_n_kbstatus
);

    scan_event_if ev ();

    logic       busy;
    logic       error;
    logic       sel_scancode;
    logic       sel_kbstatus;
    logic       sel_keymap;
    logic [6:0] status_hi;
    logic       pen;

    // ----------------------------------------
    // Register decode
    // ----------------------------------------
    assign sel_scancode = (zxuno_addr == REG_SCANCODE);
    assign sel_kbstatus = (zxuno_addr == REG_KBSTATUS);
    assign sel_keymap   = (zxuno_addr == REG_KEYMAP);

    assign oe_n_scancode = ~(sel_scancode & zxuno_regrd);
    assign oe_n_kbstatus = ~(sel_kbstatus & zxuno_regrd);
    assign oe_n_keymap   = ~(sel_keymap & zxuno_regrd);

    assign scancode_dout = ev.scancode;
    assign kbstatus_dout = {status_hi, pen};

    // BSY 0 0 0 ERR RLS EXT PEN
    always_ff @(posedge clk) begin
        if (reset) begin
            status_hi <= '0;
            pen       <= 1'b0;
        end else begin
            status_hi <= {busy, 3'b000, error, ev.released, ev.extended};
            if (ev.new_key) begin
                pen <= 1'b1;
            end else if (sel_kbstatus && zxuno_regrd) begin
                pen <= 1'b0;
            end
        end
    end

    ps2_port #(
        .FILTER_LEN (FILTER_LEN)
    ) rx_i (
        .clk         (clk),
        .reset       (reset),
        .enable_rcv  (~busy),
        .ps2_clk_in  (ps2_clk_in),
        .ps2_data_in (ps2_data_in),
        .ev          (ev)
    );

    ps2_host_to_kb #(
        .FILTER_LEN     (FILTER_LEN),
        .INHIBIT_CYCLES (INHIBIT_CYCLES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) tx_i (
        .clk           (clk),
        .reset         (reset),
        .ps2_clk_in    (ps2_clk_in),
        .ps2_data_in   (ps2_data_in),
        .ps2_clk_pull  (ps2_clk_pull),
        .ps2_data_pull (ps2_data_pull),
        .data          (din),
        .dataload      (sel_scancode & zxuno_regwr),
        .busy          (busy),
        .error         (error)
    );

    scancode_to_speccy xlat_i (
        .clk       (clk),
        .reset     (reset),
        .ev        (ev),
        .rows      (rows),
        .cols      (cols),
        .din       (din),
        .dout      (keymap_dout),
        .cpu_write (sel_keymap & zxuno_regwr),
        .cpu_read  (sel_keymap & zxuno_regrd),
        .rewind    (sel_keymap & regaddr_changed)
    );

endmodule

`default_nettype wire

/* ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    // One byte as it travels on the PS/2 data line
    typedef logic [7:0] ps2_byte_t;

    // Prefix codes sent ahead of a scancode
    localparam ps2_byte_t PS2_EXTENDED_PREFIX = 8'hE0;
    localparam ps2_byte_t PS2_RELEASE_PREFIX  = 8'hF0;

    // Device to host frame reception
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Host to device command transmission
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_INHIBIT,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP,
        TX_ACK,
        TX_DONE
    } tx_state_t;

endpackage

`default_nettype wire

/* ps2_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_port import ps2_pkg::*; #(
    parameter int FILTER_LEN = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable_rcv,
    input  logic     ps2_clk_in,
    input  logic     ps2_data_in,
    scan_event_if.rx ev
);

    localparam int FILT_W = $clog2(FILTER_LEN + 1);

    logic [1:0]        clk_sync;
    logic [1:0]        data_sync;
    logic [FILT_W-1:0] filt_cnt;
    logic              clk_filt;
    logic              fall_edge;

    rx_state_t         state;
    logic [2:0]        bit_cnt;
    ps2_byte_t         shreg;
    logic              parity_bit;
    logic              frame_done;
    logic              parity_ok;
    logic              ext_flag;
    logic              rls_flag;

    // ----------------------------------------
    // Line sync and clock filter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            filt_cnt  <= '0;
            clk_filt  <= 1'b1;
            fall_edge <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk_in};
            data_sync <= {data_sync[0], ps2_data_in};
            fall_edge <= 1'b0;
            if (clk_sync[1] == clk_filt) begin
                filt_cnt <= '0;
            end else if (filt_cnt == FILT_W'(FILTER_LEN - 1)) begin
                // Level has been different long enough, take it
                filt_cnt  <= '0;
                clk_filt  <= clk_sync[1];
                fall_edge <= clk_filt;
            end else begin
                filt_cnt <= filt_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset || !enable_rcv) begin
            state      <= RX_IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall_edge) begin
                case (state)
                    RX_IDLE: begin
                        // Start bit is a low data line
                        if (!data_sync[1]) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        state <= RX_STOP;
                    end
                    RX_STOP: begin
                        frame_done <= 1'b1;
                        state      <= RX_IDLE;
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (fall_edge && state == RX_DATA) begin
            shreg <= {data_sync[1], shreg[7:1]};
        end
        if (fall_edge && state == RX_PARITY) begin
            parity_bit <= data_sync[1];
        end
    end

    assign parity_ok = ^{parity_bit, shreg};

    // ----------------------------------------
    // Prefix decode and event output
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ev.new_key  <= 1'b0;
            ev.scancode <= '0;
            ev.extended <= 1'b0;
            ev.released <= 1'b0;
            ext_flag    <= 1'b0;
            rls_flag    <= 1'b0;
        end else begin
            ev.new_key <= 1'b0;
            if (frame_done) begin
                if (!parity_ok) begin
                    // Corrupt frame, forget any pending prefix
                    ext_flag <= 1'b0;
                    rls_flag <= 1'b0;
                end else if (shreg == PS2_EXTENDED_PREFIX) begin
                    ext_flag <= 1'b1;
                end else if (shreg == PS2_RELEASE_PREFIX) begin
                    rls_flag <= 1'b1;
                end else begin
                    ev.new_key  <= 1'b1;
                    ev.scancode <= shreg;
                    ev.extended <= ext_flag;
                    ev.released <= rls_flag;
                    ext_flag    <= 1'b0;
                    rls_flag    <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing -f files.f --top-module tb_ps2_keyb -o tb_ps2_keyb \
    && ./obj_dir/tb_ps2_keyb | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

/* scan_event_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface scan_event_if import ps2_pkg::*; ();

    logic      new_key;
    ps2_byte_t scancode;
    // Prefix flags, held until the next event
    logic      extended;
    logic      released;

    modport rx (
        output new_key, scancode, extended, released
    );

    modport rx_sink (
        input new_key, scancode, extended, released
    );

endinterface

`default_nettype wire

/* scancode_to_speccy.sv */
`timescale 1ns/1ps
`default_nettype none

module scancode_to_speccy import zxkb_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    scan_event_if.rx_sink ev,
    input  zx_row_t       rows,
    output zx_col_t       cols,
    input  keymap_entry_t din,
    output keymap_entry_t dout,
    input  logic          cpu_write,
    input  logic          cpu_read,
    input  logic          rewind
);

    // Every scancode starts out unmapped
    keymap_entry_t keymap [KEYMAP_SIZE] = '{default: KEY_NONE};

    keymap_addr_t  ptr;
    keymap_addr_t  lookup_addr;
    keymap_entry_t lookup;
    logic [2:0]    key_row;
    logic [2:0]    key_col;
    logic          key_valid;

    // One bit per key, 1 while pressed
    logic [MATRIX_ROWS-1:0][MATRIX_COLS-1:0] matrix;

    // ----------------------------------------
    // CPU side of the keymap
    // ----------------------------------------
    always @(posedge clk) begin
        if (cpu_write) begin
            keymap[ptr] <= din;
        end
    end

    assign dout = keymap[ptr];

    // Auto increment, wraps at the top of the table
    always_ff @(posedge clk) begin
        if (reset || rewind) begin
            ptr <= '0;
        end else if (cpu_write || cpu_read) begin
            ptr <= ptr + 1'b1;
        end
    end

    // ----------------------------------------
    // Scancode lookup and matrix
    // ----------------------------------------
    assign lookup_addr = {ev.extended, ev.scancode};
    assign lookup      = keymap[lookup_addr];
    assign key_row     = lookup[5:3];
    assign key_col     = lookup[2:0];
    assign key_valid   = (key_col < 3'(MATRIX_COLS));

    always_ff @(posedge clk) begin
        if (reset) begin
            matrix <= '0;
        end else if (ev.new_key && key_valid) begin
            matrix[key_row][key_col] <= ~ev.released;
        end
    end

    // Z80 selects rows low and sees pressed keys as low columns
    always_comb begin
        cols = '1;
        for (int r = 0; r < MATRIX_ROWS; r++) begin
            if (!rows[r]) begin
                cols = cols & ~matrix[r];
            end
        end
    end

endmodule

`default_nettype wire

/* tb_ps2_keyb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_keyb import ps2_pkg::*, zxkb_pkg::*; ();

    localparam int FILTER_LEN      = 2;
    localparam int INHIBIT_CYCLES  = 40;
    localparam int TIMEOUT_CYCLES  = 4000;
    localparam int HALF_BIT        = 24;
    localparam int FRAME_CYCLES    = 23 * HALF_BIT + 64;
    localparam int NUM_EVENTS      = 20;
    // Up to two events per round, three frames per event, plus the extras
    localparam int NUM_FRAMES      = NUM_EVENTS * 6 + 16;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES + 4 * TIMEOUT_CYCLES
                                     + 4 * KEYMAP_SIZE + 2000;

    logic         clk;
    logic         reset;
    logic         ps2_clk_pull;
    logic         ps2_data_pull;
    zx_row_t      rows;
    zx_col_t      cols;
    zx_reg_addr_t zxuno_addr;
    logic         zxuno_regrd;
    logic         zxuno_regwr;
    logic         regaddr_changed;
    logic [7:0]   din;
    logic [7:0]   keymap_dout;
    logic [7:0]   scancode_dout;
    logic [7:0]   kbstatus_dout;
    logic         oe_n_keymap;
    logic         oe_n_scancode;
    logic         oe_n_kbstatus;

    // Keyboard side of the open-drain lines
    logic         kb_clk_low;
    logic         kb_data_low;
    logic         ps2_clk_line;
    logic         ps2_data_line;

    logic [31:0]   lfsr;
    keymap_entry_t model_keymap [KEYMAP_SIZE];
    zx_col_t       model_matrix [MATRIX_ROWS];
    logic          model_err;

    assign ps2_clk_line  = ~(kb_clk_low | ps2_clk_pull);
    assign ps2_data_line = ~(kb_data_low | ps2_data_pull);

    ps2_keyb #(
        .FILTER_LEN     (FILTER_LEN),
        .INHIBIT_CYCLES (INHIBIT_CYCLES),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut_i (
        .clk             (clk),
        .reset           (reset),
        .ps2_clk_in      (ps2_clk_line),
        .ps2_data_in     (ps2_data_line),
        .ps2_clk_pull    (ps2_clk_pull),
        .ps2_data_pull   (ps2_data_pull),
        .rows            (rows),
        .cols            (cols),
        .zxuno_addr      (zxuno_addr),
        .zxuno_regrd     (zxuno_regrd),
        .zxuno_regwr     (zxuno_regwr),
        .regaddr_changed (regaddr_changed),
        .din             (din),
        .keymap_dout     (keymap_dout),
        .scancode_dout   (scancode_dout),
        .kbstatus_dout   (kbstatus_dout),
        .oe_n_keymap     (oe_n_keymap),
        .oe_n_scancode   (oe_n_scancode),
        .oe_n_kbstatus   (oe_n_kbstatus)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: watchdog expired, the run did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog");
    end

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic ps2_byte_t rand_scancode();
        ps2_byte_t b;
        b = rand_bits(8);
        // Prefix codes never stand as a scancode
        if (b == PS2_EXTENDED_PREFIX || b == PS2_RELEASE_PREFIX) begin
            b = b ^ 8'h01;
        end
        return b;
    endfunction

    // Odd parity bit, set when the byte holds an even number of ones
    function automatic logic odd_parity(input ps2_byte_t b);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += b[i];
        end
        return (ones % 2) == 0;
    endfunction

    function automatic zx_col_t expected_cols(input zx_row_t sel);
        zx_col_t c;
        c = '1;
        for (int r = 0; r < MATRIX_ROWS; r++) begin
            if (!sel[r]) begin
                c = c & ~model_matrix[r];
            end
        end
        return c;
    endfunction

    task automatic apply_event(input ps2_byte_t code, input logic ext, input logic rls);
        keymap_entry_t entry;
        entry = model_keymap[{ext, code}];
        // Columns 5 to 7 are not keys
        if (entry[2:0] < 3'd5) begin
            model_matrix[entry[5:3]][entry[2:0]] = ~rls;
        end
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("Fail %s: got %h, expected %h", name, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("Error: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", what);
    endtask

    // ----------------------------------------
    // Bus and line drivers
    // ----------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic reg_write(input zx_reg_addr_t addr, input logic [7:0] data);
        zxuno_addr  = addr;
        din         = data;
        zxuno_regwr = 1'b1;
        wait_cycles(1);
        zxuno_regwr = 1'b0;
    endtask

    task automatic reg_read(input zx_reg_addr_t addr, output logic [7:0] value,
                            output logic oe_n);
        zxuno_addr  = addr;
        zxuno_regrd = 1'b1;
        @(negedge clk);
        case (addr)
            REG_SCANCODE: begin
                value = scancode_dout;
                oe_n  = oe_n_scancode;
            end
            REG_KBSTATUS: begin
                value = kbstatus_dout;
                oe_n  = oe_n_kbstatus;
            end
            default: begin
                value = keymap_dout;
                oe_n  = oe_n_keymap;
            end
        endcase
        wait_cycles(1);
        zxuno_regrd = 1'b0;
    endtask

    task automatic rewind_keymap();
        zxuno_addr      = REG_KEYMAP;
        regaddr_changed = 1'b1;
        wait_cycles(1);
        regaddr_changed = 1'b0;
    endtask

    // Device to host frame, data changes while the clock is high
    task automatic send_frame(input ps2_byte_t data, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = odd_parity(data) ^ bad_parity;
        bits   = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            kb_data_low = ~bits[i];
            wait_cycles(HALF_BIT);
            kb_clk_low = 1'b1;
            wait_cycles(HALF_BIT);
            kb_clk_low = 1'b0;
        end
        kb_data_low = 1'b0;
        wait_cycles(HALF_BIT);
    endtask

    // Keyboard answering a host command
    task automatic device_receive(input logic ack, output ps2_byte_t data,
                                  output logic parity, output logic stop);
        logic [10:0] got;
        wait (ps2_clk_line === 1'b0);
        wait (ps2_clk_line === 1'b1 && ps2_data_line === 1'b0);
        wait_cycles(1);
        for (int i = 0; i < 11; i++) begin
            wait_cycles(HALF_BIT);
            kb_clk_low = 1'b1;
            wait_cycles(HALF_BIT);
            kb_clk_low = 1'b0;
            got[i] = ps2_data_line;
            if (i == 9 && ack) begin
                kb_data_low = 1'b1;
            end
        end
        wait_cycles(HALF_BIT);
        kb_data_low = 1'b0;
        data   = got[7:0];
        parity = got[8];
        stop   = got[9];
    endtask

    task automatic wait_for_pen();
        int n;
        n = 0;
        while (kbstatus_dout[0] !== 1'b1) begin
            if (n == 64) begin
                stop_on_error("no scancode event after a good frame");
            end else begin
                wait_cycles(1);
                n++;
            end
        end
    endtask

    task automatic wait_not_busy(input int limit);
        int n;
        n = 0;
        while (kbstatus_dout[7] !== 1'b0) begin
            if (n == limit) begin
                stop_on_error("sender stayed busy");
            end else begin
                wait_cycles(1);
                n++;
            end
        end
    endtask

    // ----------------------------------------
    // Test steps
    // ----------------------------------------
    task automatic check_cols();
        repeat (3) begin
            rows = rand_bits(8);
            @(negedge clk);
            check_value("cols", {3'b000, cols}, {3'b000, expected_cols(rows)});
            wait_cycles(1);
        end
        rows = '1;
    endtask

    task automatic key_event(input ps2_byte_t code, input logic ext, input logic rls);
        logic [7:0] value;
        logic       oe_n;
        if (ext) begin
            send_frame(PS2_EXTENDED_PREFIX, 1'b0);
        end
        if (rls) begin
            send_frame(PS2_RELEASE_PREFIX, 1'b0);
        end
        send_frame(code, 1'b0);
        wait_for_pen();
        apply_event(code, ext, rls);
        reg_read(REG_SCANCODE, value, oe_n);
        check_value("oe_n_scancode", {7'b0, oe_n}, 8'h00);
        check_value("scancode_dout", value, code);
        reg_read(REG_KBSTATUS, value, oe_n);
        check_value("oe_n_kbstatus", {7'b0, oe_n}, 8'h00);
        check_value("kbstatus_dout", value, {1'b0, 3'b000, model_err, rls, ext, 1'b1});
        // PEN gone after the status read
        @(negedge clk);
        check_value("kbstatus_dout[0]", {7'b0, kbstatus_dout[0]}, 8'h00);
        wait_cycles(1);
        check_cols();
    endtask

    task automatic host_write(input ps2_byte_t data, input logic ack);
        ps2_byte_t got_data;
        logic      got_par;
        logic      got_stop;
        fork
            reg_write(REG_SCANCODE, data);
            device_receive(ack, got_data, got_par, got_stop);
        join
        check_value("device data", got_data, data);
        check_value("device parity", {7'b0, got_par}, {7'b0, odd_parity(data)});
        check_value("device stop", {7'b0, got_stop}, 8'h01);
        wait_not_busy(TIMEOUT_CYCLES + 100);
        model_err = ~ack;
        @(negedge clk);
        check_value("kbstatus_dout[7:3]", {3'b000, kbstatus_dout[7:3]}, {7'b0, model_err});
        wait_cycles(1);
    endtask

    initial begin
        logic [7:0] value;
        logic       oe_n;
        ps2_byte_t  code;
        logic       ext;

        reset           = 1'b1;
        rows            = '1;
        zxuno_addr      = '0;
        zxuno_regrd     = 1'b0;
        zxuno_regwr     = 1'b0;
        regaddr_changed = 1'b0;
        din             = '0;
        kb_clk_low      = 1'b0;
        kb_data_low     = 1'b0;
        lfsr            = 32'h577b;
        model_err       = 1'b0;
        for (int r = 0; r < MATRIX_ROWS; r++) begin
            model_matrix[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_cycles(2);

        // Idle state after reset
        rows = '0;
        @(negedge clk);
        check_value("cols", {3'b000, cols}, 8'h1f);
        check_value("kbstatus_dout", kbstatus_dout, 8'h00);
        check_value("ps2_pulls", {6'b0, ps2_clk_pull, ps2_data_pull}, 8'h00);
        wait_cycles(1);
        rows = '1;

        // Keymap load and readback
        rewind_keymap();
        for (int i = 0; i < KEYMAP_SIZE; i++) begin
            model_keymap[i] = rand_bits(8);
            reg_write(REG_KEYMAP, model_keymap[i]);
        end
        rewind_keymap();
        for (int i = 0; i < KEYMAP_SIZE; i++) begin
            reg_read(REG_KEYMAP, value, oe_n);
            check_value("oe_n_keymap", {7'b0, oe_n}, 8'h00);
            check_value("keymap_dout", value, model_keymap[i]);
            @(negedge clk);
            check_value("oe_n_keymap", {7'b0, oe_n_keymap}, 8'h01);
            wait_cycles(1);
        end

        // Presses, some followed by their release
        for (int n = 0; n < NUM_EVENTS; n++) begin
            code = rand_scancode();
            ext  = (rand_bits(1) != 8'h00);
            key_event(code, ext, 1'b0);
            if (rand_bits(1) != 8'h00) begin
                key_event(code, ext, 1'b1);
            end
        end

        // Bad parity drops the frame and the pending prefix
        send_frame(PS2_EXTENDED_PREFIX, 1'b0);
        send_frame(rand_scancode(), 1'b1);
        wait_cycles(16);
        @(negedge clk);
        check_value("kbstatus_dout[0]", {7'b0, kbstatus_dout[0]}, 8'h00);
        wait_cycles(1);
        check_cols();
        key_event(rand_scancode(), 1'b0, 1'b0);

        // Host commands with and without ack
        host_write(rand_bits(8), 1'b1);
        host_write(rand_bits(8), 1'b0);
        host_write(rand_bits(8), 1'b1);

        // Frame during a transfer that the device never answers
        // All ones keeps the host off the data line, so the frame arrives intact
        reg_write(REG_SCANCODE, 8'hff);
        wait (ps2_clk_line === 1'b0);
        wait (ps2_clk_line === 1'b1);
        @(negedge clk);
        check_value("kbstatus_dout[7]", {7'b0, kbstatus_dout[7]}, 8'h01);
        wait_cycles(1);
        send_frame(rand_scancode(), 1'b0);
        wait_not_busy(TIMEOUT_CYCLES + 100);
        model_err = 1'b1;
        @(negedge clk);
        check_value("kbstatus_dout[0]", {7'b0, kbstatus_dout[0]}, 8'h00);
        check_value("kbstatus_dout[3]", {7'b0, kbstatus_dout[3]}, 8'h01);
        wait_cycles(1);
        check_cols();

        // Receiver back in service
        key_event(rand_scancode(), 1'b1, 1'b0);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* zxkb_pkg.sv */
`default_nettype none

package zxkb_pkg;

    // Register bus
    typedef logic [7:0] zx_reg_addr_t;

    localparam zx_reg_addr_t REG_SCANCODE = 8'h04;
    localparam zx_reg_addr_t REG_KBSTATUS = 8'h05;
    localparam zx_reg_addr_t REG_KEYMAP   = 8'h07;

    // Keymap index is {extended, scancode}
    typedef logic [8:0] keymap_addr_t;
    localparam int KEYMAP_SIZE = 512;

    // Entry layout: [5:3] row, [2:0] column, column 7 means no key
    typedef logic [7:0] keymap_entry_t;
    localparam keymap_entry_t KEY_NONE = 8'h07;

    // Spectrum key matrix, both sides active low
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 5;
    typedef logic [MATRIX_ROWS-1:0] zx_row_t;
    typedef logic [MATRIX_COLS-1:0] zx_col_t;

endpackage

`default_nettype wire
